//--- axis_reg_slice.sv
// Two-entry valid/ready skid slice, full throughput, one cycle of latency
// in_tready comes straight from a register and never from out_tready
`timescale 1ns/1ns

module axis_reg_slice
  import stream_pkg::*;
(
  input  logic         aclk,
  input  logic         rst_n,

  input  stream_word_t in_tdata,
  input  logic         in_tvalid,
  output logic         in_tready,

  output stream_word_t out_tdata,
  output logic         out_tvalid,
  input  logic         out_tready
);

  logic         main_valid;
  stream_word_t main_data;
  logic         skid_valid;
  stream_word_t skid_data;

  logic accept;
  logic main_load;

  assign accept = in_tvalid && in_tready;

  // Main register may take a new word when empty or being drained
  assign main_load = !main_valid || out_tready;

  // Ready only while the skid entry is free
  assign in_tready = !skid_valid;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_load) begin
      if (skid_valid) begin
        // Skid word moves up, input is stalled this cycle
        main_valid <= 1'b1;
        skid_valid <= 1'b0;
      end else begin
        main_valid <= accept;
      end
    end else if (accept) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (main_load) begin
      if (skid_valid) begin
        main_data <= skid_data;
      end else if (accept) begin
        main_data <= in_tdata;
      end
    end else if (accept) begin
      skid_data <= in_tdata;
    end
  end

  assign out_tdata  = main_data;
  assign out_tvalid = main_valid;

  // A stalled output word holds until it is taken
  a_out_hold: assert property (
    @(posedge aclk) disable iff (!rst_n)
    (out_tvalid && !out_tready) |=> (out_tvalid && $stable(out_tdata))
  );

endmodule

//--- crossbar_3x2.sv
// Combinational 3-to-2 steering of data, valid and ready by the current route
// The unmapped input always sees tready low
`timescale 1ns/1ns

module crossbar_3x2
  import stream_pkg::*;
  import route_pkg::*;
(
  input  logic         aclk,
  input  logic         rst_n,

  input  stream_word_t in0_tdata,
  input  stream_word_t in1_tdata,
  input  stream_word_t in2_tdata,
  input  logic         in0_tvalid,
  input  logic         in1_tvalid,
  input  logic         in2_tvalid,
  output logic         in0_tready,
  output logic         in1_tready,
  output logic         in2_tready,

  output stream_word_t out0_tdata,
  output stream_word_t out1_tdata,
  output logic         out0_tvalid,
  output logic         out1_tvalid,
  input  logic         out0_tready,
  input  logic         out1_tready
);

  route_t    route;
  port_idx_t src0;
  port_idx_t src1;
  port_idx_t idle;

  stream_word_t          in_data [num_inputs];
  logic [num_inputs-1:0] in_valid;
  logic [num_inputs-1:0] in_ready;

  logic fire0;
  logic fire1;
  logic idle_valid;

  assign in_data[0] = in0_tdata;
  assign in_data[1] = in1_tdata;
  assign in_data[2] = in2_tdata;
  assign in_valid   = {in2_tvalid, in1_tvalid, in0_tvalid};

  // Table lookups for the current route
  assign src0 = out0_src[route];
  assign src1 = out1_src[route];
  assign idle = idle_src[route];

  assign out0_tdata  = in_data[src0];
  assign out0_tvalid = in_valid[src0];
  assign out1_tdata  = in_data[src1];
  assign out1_tvalid = in_valid[src1];

  // Mapped inputs see their output's ready
  always_comb begin
    in_ready       = '0;
    in_ready[src0] = out0_tready;
    in_ready[src1] = out1_tready;
  end

  assign in0_tready = in_ready[0];
  assign in1_tready = in_ready[1];
  assign in2_tready = in_ready[2];

  assign fire0      = out0_tvalid && out0_tready;
  assign fire1      = out1_tvalid && out1_tready;
  assign idle_valid = in_valid[idle];

  route_arbiter u_route_arbiter (
    .aclk       (aclk),
    .rst_n      (rst_n),
    .fire0      (fire0),
    .fire1      (fire1),
    .idle_valid (idle_valid),
    .route      (route)
  );

  // Unmapped input is never ready
  a_idle_not_ready: assert property (
    @(posedge aclk) disable iff (!rst_n)
    !((route == ROUTE_A && in2_tready) ||
      (route == ROUTE_B && in0_tready) ||
      (route == ROUTE_C && in1_tready))
  );

  // Output data follows the route definition itself
  a_out0_data: assert property (
    @(posedge aclk) disable iff (!rst_n)
    out0_tdata == (route == ROUTE_A ? in0_tdata :
                   route == ROUTE_B ? in1_tdata : in2_tdata)
  );

  a_out1_data: assert property (
    @(posedge aclk) disable iff (!rst_n)
    out1_tdata == (route == ROUTE_A ? in1_tdata :
                   route == ROUTE_B ? in2_tdata : in0_tdata)
  );

endmodule

//--- route_arbiter.sv
// Rotating route state with at most one step per edge
// Advances on any output transfer, or when only the idle input is waiting
`timescale 1ns/1ns

module route_arbiter
  import stream_pkg::*;
  import route_pkg::*;
(
  input  logic   aclk,
  input  logic   rst_n,

  input  logic   fire0,
  input  logic   fire1,
  input  logic   idle_valid,

  output route_t route
);

  logic [num_outputs-1:0] fire_vec;
  logic                   advance;
  route_t                 route_q;

  assign fire_vec = {fire1, fire0};

  // An idle input with nothing moving still forces a rotation,
  // so no input is starved by a stalled route
  assign advance = (|fire_vec) || idle_valid;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      route_q <= route_reset;
    end else if (advance) begin
      route_q <= route_next[route_q];
    end
  end

  assign route = route_q;

  // Only the three legal encodings
  a_route_legal: assert property (
    @(posedge aclk) disable iff (!rst_n)
    route inside {ROUTE_A, ROUTE_B, ROUTE_C}
  );

  // Either hold or take exactly one rotation step
  a_route_step: assert property (
    @(posedge aclk) disable iff (!rst_n)
    (route != $past(route)) |-> (route == route_next[$past(route)])
  );

endmodule

//--- route_pkg.sv
// Route encoding and the fixed input-to-output mapping tables
// Encoding 3 is illegal and is never produced by the arbiter
package route_pkg;

  typedef enum logic [1:0] {
    ROUTE_A = 2'd0,
    ROUTE_B = 2'd1,
    ROUTE_C = 2'd2
  } route_t;

  // Index of one of the three input streams
  typedef logic [1:0] port_idx_t;

  localparam route_t route_reset = ROUTE_A;

  // Rotation order A -> B -> C -> A
  localparam route_t route_next [3] = '{ROUTE_B, ROUTE_C, ROUTE_A};

  // Input feeding out0, per route
  localparam port_idx_t out0_src [3] = '{2'd0, 2'd1, 2'd2};

  // Input feeding out1, per route
  localparam port_idx_t out1_src [3] = '{2'd1, 2'd2, 2'd0};

  // The input left without an output, per route
  localparam port_idx_t idle_src [3] = '{2'd2, 2'd0, 2'd1};

endpackage

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for failure
verilator --binary --assert -Wno-fatal --top-module tb_stream_xbar -f sources.f \
  -o sim_stream_xbar > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
./obj_dir/sim_stream_xbar > sim.log 2>&1 || { cat sim.log; echo "simulator error"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "simulation ended early"; exit 1; }
exit 0

//--- sources.f
stream_pkg.sv
route_pkg.sv
axis_reg_slice.sv
route_arbiter.sv
crossbar_3x2.sv
stream_xbar_top.sv
tb_stream_xbar.sv

//--- stream_pkg.sv
// Stream word and port counts, shared by the RTL and the testbench
// Word width is fixed at 32 bits and there is no sideband
package stream_pkg;

  // Bits per stream word
  localparam int unsigned data_width = 32;

  // One word on any stream port
  typedef logic [data_width-1:0] stream_word_t;

  // Port counts of the switch
  localparam int unsigned num_inputs  = 3;
  localparam int unsigned num_outputs = 2;

endpackage

//--- stream_xbar_top.sv
// Stream switch: three ingress slices, route crossbar, two egress slices
// Minimum latency input to output is two edges, more under back-pressure
`timescale 1ns/1ns

module stream_xbar_top
  import stream_pkg::*;
(
  input  logic         aclk,
  input  logic         rst_n,

  input  stream_word_t s0_tdata,
  input  logic         s0_tvalid,
  output logic         s0_tready,
  input  stream_word_t s1_tdata,
  input  logic         s1_tvalid,
  output logic         s1_tready,
  input  stream_word_t s2_tdata,
  input  logic         s2_tvalid,
  output logic         s2_tready,

  output stream_word_t m0_tdata,
  output logic         m0_tvalid,
  input  logic         m0_tready,
  output stream_word_t m1_tdata,
  output logic         m1_tvalid,
  input  logic         m1_tready
);

  // Ingress slice to crossbar
  stream_word_t ing0_tdata;
  stream_word_t ing1_tdata;
  stream_word_t ing2_tdata;
  logic         ing0_tvalid;
  logic         ing1_tvalid;
  logic         ing2_tvalid;
  logic         ing0_tready;
  logic         ing1_tready;
  logic         ing2_tready;

  // Crossbar to egress slice
  stream_word_t egr0_tdata;
  stream_word_t egr1_tdata;
  logic         egr0_tvalid;
  logic         egr1_tvalid;
  logic         egr0_tready;
  logic         egr1_tready;

  axis_reg_slice u_ing0 (
    .aclk       (aclk),
    .rst_n      (rst_n),
    .in_tdata   (s0_tdata),
    .in_tvalid  (s0_tvalid),
    .in_tready  (s0_tready),
    .out_tdata  (ing0_tdata),
    .out_tvalid (ing0_tvalid),
    .out_tready (ing0_tready)
  );

  axis_reg_slice u_ing1 (
    .aclk       (aclk),
    .rst_n      (rst_n),
    .in_tdata   (s1_tdata),
    .in_tvalid  (s1_tvalid),
    .in_tready  (s1_tready),
    .out_tdata  (ing1_tdata),
    .out_tvalid (ing1_tvalid),
    .out_tready (ing1_tready)
  );

  axis_reg_slice u_ing2 (
    .aclk       (aclk),
    .rst_n      (rst_n),
    .in_tdata   (s2_tdata),
    .in_tvalid  (s2_tvalid),
    .in_tready  (s2_tready),
    .out_tdata  (ing2_tdata),
    .out_tvalid (ing2_tvalid),
    .out_tready (ing2_tready)
  );

  crossbar_3x2 u_xbar (
    .aclk        (aclk),
    .rst_n       (rst_n),
    .in0_tdata   (ing0_tdata),
    .in1_tdata   (ing1_tdata),
    .in2_tdata   (ing2_tdata),
    .in0_tvalid  (ing0_tvalid),
    .in1_tvalid  (ing1_tvalid),
    .in2_tvalid  (ing2_tvalid),
    .in0_tready  (ing0_tready),
    .in1_tready  (ing1_tready),
    .in2_tready  (ing2_tready),
    .out0_tdata  (egr0_tdata),
    .out1_tdata  (egr1_tdata),
    .out0_tvalid (egr0_tvalid),
    .out1_tvalid (egr1_tvalid),
    .out0_tready (egr0_tready),
    .out1_tready (egr1_tready)
  );

  axis_reg_slice u_egr0 (
    .aclk       (aclk),
    .rst_n      (rst_n),
    .in_tdata   (egr0_tdata),
    .in_tvalid  (egr0_tvalid),
    .in_tready  (egr0_tready),
    .out_tdata  (m0_tdata),
    .out_tvalid (m0_tvalid),
    .out_tready (m0_tready)
  );

  axis_reg_slice u_egr1 (
    .aclk       (aclk),
    .rst_n      (rst_n),
    .in_tdata   (egr1_tdata),
    .in_tvalid  (egr1_tvalid),
    .in_tready  (egr1_tready),
    .out_tdata  (m1_tdata),
    .out_tvalid (m1_tvalid),
    .out_tready (m1_tready)
  );

endmodule

//--- tb_stream_xbar.sv
// Words carry the source index in bits 31:30 and the sequence number in bits 15:0
// Inputs change 1 ns after the rising edge and outputs are sampled on the falling edge
`timescale 1ns/1ns

module tb_stream_xbar
  import stream_pkg::*;
();

  localparam int single_words = 20;
  localparam int conc_words   = 24;
  localparam int bp_words     = 16;
  localparam int rand_words   = 60;
  localparam int rand_cycles  = 300;
  localparam int max_words    = 64;
  localparam int timeout_cycles =
    (single_words + 3 * (conc_words + bp_words + rand_words)) * 8 + 200;

  logic         aclk;
  logic         rst_n;
  logic         src_valid  [num_inputs];
  stream_word_t src_data   [num_inputs];
  logic         src_ready  [num_inputs];
  logic         sink_ready [num_outputs];
  logic         mon_valid  [num_outputs];
  stream_word_t mon_data   [num_outputs];

  int errors = 0;
  int checks = 0;
  int cycle_count = 0;
  int test_mark;
  int rx_total;
  int exp_total;
  int exp_count [num_inputs];
  int got_count [num_inputs];
  int seen      [num_inputs][max_words];
  int last_seq  [num_outputs][num_inputs];
  logic         stalled [num_outputs];
  stream_word_t held    [num_outputs];

  stream_xbar_top u_dut (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .s0_tdata  (src_data[0]),
    .s0_tvalid (src_valid[0]),
    .s0_tready (src_ready[0]),
    .s1_tdata  (src_data[1]),
    .s1_tvalid (src_valid[1]),
    .s1_tready (src_ready[1]),
    .s2_tdata  (src_data[2]),
    .s2_tvalid (src_valid[2]),
    .s2_tready (src_ready[2]),
    .m0_tdata  (mon_data[0]),
    .m0_tvalid (mon_valid[0]),
    .m0_tready (sink_ready[0]),
    .m1_tdata  (mon_data[1]),
    .m1_tvalid (mon_valid[1]),
    .m1_tready (sink_ready[1])
  );

  initial aclk = 1'b0;
  always #2 aclk = ~aclk;

  always @(posedge aclk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: run still busy after %0d cycles", cycle_count);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // Filler bits mix source and sequence so a corrupted word shows up
  function automatic stream_word_t make_word(int src, int seq);
    logic [13:0] mid;
    mid = 14'((seq * 37) ^ (src * 1331));
    return {src[1:0], mid, seq[15:0]};
  endfunction

  task automatic report_error(string msg);
    errors++;
    $display("ERROR: %s", msg);
  endtask

  task automatic check_word(string name, stream_word_t exp, stream_word_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s: expected 'h%h, got 'h%h", name, exp, act);
    end
  endtask

  task automatic check_count(string name, int exp, int act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s: expected 'h%0h, got 'h%0h", name, exp, act);
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s: expected 'h%h, got 'h%h", name, exp, act);
    end
  endtask

  task automatic record_word(int sink, stream_word_t w);
    int src;
    int seq;
    src = int'(w[31:30]);
    seq = int'(w[15:0]);
    rx_total++;
    if (src >= num_inputs) begin
      report_error($sformatf("sink %0d got word %h from no known source", sink, w));
    end else if (seq >= exp_count[src]) begin
      report_error($sformatf("sink %0d got word %h that was never sent", sink, w));
    end else begin
      got_count[src]++;
      check_word($sformatf("m%0d_tdata", sink), make_word(src, seq), w);
      if (seq <= last_seq[sink][src]) begin
        report_error($sformatf("sink %0d got source %0d word %0d out of order", sink, src, seq));
      end
      last_seq[sink][src] = seq;
      seen[src][seq]++;
    end
  endtask

  // Output monitor and hold check on a stalled output
  always @(negedge aclk) begin
    for (int k = 0; k < num_outputs; k++) begin
      if (rst_n && stalled[k]) begin
        check_flag($sformatf("m%0d_tvalid", k), 1'b1, mon_valid[k]);
        check_word($sformatf("m%0d_tdata", k), held[k], mon_data[k]);
      end
      if (rst_n && mon_valid[k] && sink_ready[k]) begin
        record_word(k, mon_data[k]);
      end
      stalled[k] = rst_n && mon_valid[k] && !sink_ready[k];
      held[k] = mon_data[k];
    end
  end

  task automatic sync_drive();
    @(posedge aclk);
    #1;
  endtask

  // Sends from one source and holds each word until the DUT takes it
  task automatic send_words(int src, int count, bit gaps);
    int seq;
    bit taken;
    seq = 0;
    while (seq < count) begin
      if (!src_valid[src] && (!gaps || $urandom_range(0, 1) == 1)) begin
        src_valid[src] = 1'b1;
        src_data[src] = make_word(src, seq);
      end
      @(negedge aclk);
      taken = src_valid[src] && src_ready[src];
      sync_drive();
      if (taken) begin
        seq++;
        src_valid[src] = 1'b0;
      end
    end
  endtask

  task automatic drive_sink_random(int cycles);
    repeat (cycles) begin
      sink_ready[0] = 1'($urandom_range(0, 1));
      sink_ready[1] = 1'($urandom_range(0, 1));
      sync_drive();
    end
    sink_ready[0] = 1'b1;
    sink_ready[1] = 1'b1;
  endtask

  task automatic hold_sink(int k, int cycles);
    sink_ready[k] = 1'b0;
    repeat (cycles) sync_drive();
    sink_ready[k] = 1'b1;
  endtask

  task automatic begin_test(int c0, int c1, int c2);
    exp_count[0] = c0;
    exp_count[1] = c1;
    exp_count[2] = c2;
    exp_total = c0 + c1 + c2;
    rx_total = 0;
    for (int s = 0; s < num_inputs; s++) begin
      got_count[s] = 0;
      for (int q = 0; q < max_words; q++) seen[s][q] = 0;
      for (int k = 0; k < num_outputs; k++) last_seq[k][s] = -1;
    end
    test_mark = errors;
  endtask

  task automatic wait_drain();
    while (rx_total < exp_total) @(negedge aclk);
    // A few idle cycles so a duplicated word still gets counted
    repeat (10) @(negedge aclk);
    sync_drive();
  endtask

  task automatic end_test(string name);
    for (int s = 0; s < num_inputs; s++) begin
      check_count($sformatf("source %0d word count", s), exp_count[s], got_count[s]);
      for (int q = 0; q < exp_count[s]; q++) begin
        check_count($sformatf("source %0d word %0d arrivals", s, q), 1, seen[s][q]);
      end
    end
    if (errors == test_mark) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, errors - test_mark);
  endtask

  task automatic test_reset_state();
    begin_test(0, 0, 0);
    repeat (2) @(negedge aclk);
    check_flag("m0_tvalid", 1'b0, mon_valid[0]);
    check_flag("m1_tvalid", 1'b0, mon_valid[1]);
    check_flag("s0_tready", 1'b1, src_ready[0]);
    check_flag("s1_tready", 1'b1, src_ready[1]);
    check_flag("s2_tready", 1'b1, src_ready[2]);
    sync_drive();
    end_test("reset state");
  endtask

  task automatic test_single_source();
    begin_test(single_words, 0, 0);
    send_words(0, single_words, 1'b0);
    wait_drain();
    end_test("single source");
  endtask

  task automatic test_all_sources();
    begin_test(conc_words, conc_words, conc_words);
    fork
      send_words(0, conc_words, 1'b0);
      send_words(1, conc_words, 1'b0);
      send_words(2, conc_words, 1'b0);
    join
    wait_drain();
    end_test("all sources");
  endtask

  task automatic test_back_pressure();
    begin_test(bp_words, bp_words, bp_words);
    fork
      send_words(0, bp_words, 1'b0);
      send_words(1, bp_words, 1'b0);
      send_words(2, bp_words, 1'b0);
      hold_sink(1, 40);
    join
    wait_drain();
    end_test("held back-pressure");
  endtask

  task automatic test_random_traffic();
    begin_test(rand_words, rand_words, rand_words);
    fork
      send_words(0, rand_words, 1'b1);
      send_words(1, rand_words, 1'b1);
      send_words(2, rand_words, 1'b1);
      drive_sink_random(rand_cycles);
    join
    wait_drain();
    end_test("random traffic");
  endtask

  initial begin
    void'($urandom(67238));
    rst_n = 1'b0;
    for (int s = 0; s < num_inputs; s++) begin
      src_valid[s] = 1'b0;
      src_data[s] = '0;
    end
    sink_ready[0] = 1'b1;
    sink_ready[1] = 1'b1;
    repeat (3) @(posedge aclk);
    #1;
    rst_n = 1'b1;

    test_reset_state();
    test_single_source();
    test_all_sources();
    test_back_pressure();
    test_random_traffic();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
